//--- design/axil_cache_port.sv
// Module axil_cache_port: AXI4-Lite slave with request checks and response holding
`timescale 1ns/1ps
`include "cache_macros.svh"

module axil_cache_port (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     awvalid,
    output logic                     awready,
    input  logic [`CACHE_ADDR_W-1:0] awaddr,
    input  logic                     wvalid,
    output logic                     wready,
    input  cache_pkg::word_t         wdata,
    input  logic [3:0]               wstrb,
    output logic                     bvalid,
    input  logic                     bready,
    output cache_pkg::resp_t         bresp,
    input  logic                     arvalid,
    output logic                     arready,
    input  logic [`CACHE_ADDR_W-1:0] araddr,
    output logic                     rvalid,
    input  logic                     rready,
    output cache_pkg::word_t         rdata,
    output cache_pkg::resp_t         rresp,
    output logic                     req_valid,
    output logic                     req_wr,
    output logic [`CACHE_ADDR_W-1:0] req_addr,
    output cache_pkg::word_t         req_wdata,
    input  logic                     req_ready,
    input  logic                     rsp_valid,
    input  cache_pkg::word_t         rsp_rdata
);

    import cache_pkg::*;

    typedef enum logic [1:0] {
        P_IDLE,
        P_BUSY,
        P_RESP
    } pstate_t;

    pstate_t state;
    logic    aw_held;
    logic    w_held;
    logic    op_wr;
    logic    [`CACHE_ADDR_W-1:0] aw_addr_q;
    logic    [`CACHE_ADDR_W-1:0] cur_addr;
    word_t   wdata_q;
    word_t   cur_wdata;
    logic    [3:0] wstrb_q;
    logic    [3:0] cur_strb;
    logic    accept;
    logic    rd_go;
    logic    wr_go;
    logic    bad;

    // Readies only while idle, AR wins over AW and W
    assign accept  = (state == P_IDLE) & req_ready;
    assign arready = accept;
    assign awready = accept & ~arvalid & ~aw_held;
    assign wready  = accept & ~arvalid & ~w_held;

    // A write goes once both halves are held or arriving
    assign rd_go = arvalid & arready;
    assign wr_go = accept & ~arvalid & (aw_held | awvalid) & (w_held | wvalid);

    assign cur_addr  = rd_go ? araddr : (aw_held ? aw_addr_q : awaddr);
    assign cur_wdata = w_held ? wdata_q : wdata;
    assign cur_strb  = w_held ? wstrb_q : wstrb;

    // Misaligned or partial-strobe requests never reach the cache
    assign bad = (cur_addr[1:0] != 2'b00) | (wr_go & (cur_strb != 4'hf));

    assign req_valid = (rd_go | wr_go) & ~bad;
    assign req_wr    = wr_go;
    assign req_addr  = cur_addr;
    assign req_wdata = cur_wdata;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= P_IDLE;
            aw_held <= 1'b0;
            w_held  <= 1'b0;
            op_wr   <= 1'b0;
            bvalid  <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            if (awvalid & awready) begin
                aw_held <= 1'b1;
            end
            if (wvalid & wready) begin
                w_held <= 1'b1;
            end
            case (state)
                P_IDLE: begin
                    if (rd_go | wr_go) begin
                        op_wr <= wr_go;
                        if (wr_go) begin
                            aw_held <= 1'b0;
                            w_held  <= 1'b0;
                        end
                        if (bad) begin
                            state  <= P_RESP;
                            bvalid <= wr_go;
                            rvalid <= rd_go;
                        end else begin
                            state <= P_BUSY;
                        end
                    end
                end
                P_BUSY: begin
                    if (rsp_valid) begin
                        state  <= P_RESP;
                        bvalid <= op_wr;
                        rvalid <= ~op_wr;
                    end
                end
                // Held until the master takes it
                P_RESP: begin
                    if ((bvalid & bready) | (rvalid & rready)) begin
                        state  <= P_IDLE;
                        bvalid <= 1'b0;
                        rvalid <= 1'b0;
                    end
                end
                default: state <= P_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (awvalid & awready) begin
            aw_addr_q <= awaddr;
        end
        if (wvalid & wready) begin
            wdata_q <= wdata;
            wstrb_q <= wstrb;
        end
        if (state == P_IDLE && (rd_go | wr_go) && bad) begin
            bresp <= RESP_SLVERR;
            rresp <= RESP_SLVERR;
            rdata <= '0;
        end else if (state == P_BUSY && rsp_valid) begin
            bresp <= RESP_OKAY;
            rresp <= RESP_OKAY;
            rdata <= rsp_rdata;
        end
    end

endmodule

//--- design/cache_ctrl.sv
// Module cache_ctrl: miss FSM for lookup, writeback, fill and write merge
`timescale 1ns/1ps
`include "cache_macros.svh"

module cache_ctrl (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     req_valid,
    input  logic                     req_wr,
    input  logic [`CACHE_ADDR_W-1:0] req_addr,
    input  cache_pkg::word_t         req_wdata,
    output logic                     req_ready,
    output logic                     rsp_valid,
    output cache_pkg::word_t         rsp_rdata,
    output logic                     mem_req,
    output logic                     mem_wr,
    output logic [`CACHE_ADDR_W-1:0] mem_addr,
    output cache_pkg::line_t         mem_wline,
    input  logic                     mem_ack,
    input  cache_pkg::line_t         mem_rline,
    output logic                     en,
    output logic                     comp,
    output logic                     wr,
    output logic                     replace_line,
    output cache_pkg::tag_t          tag_in,
    output cache_pkg::index_t        index,
    output cache_pkg::word_sel_t     word_sel,
    output cache_pkg::word_t         data_in,
    output cache_pkg::line_t         line_in,
    input  cache_pkg::word_t         data_out,
    input  cache_pkg::line_t         line_out,
    input  cache_pkg::tag_t          tag_out,
    input  logic                     hit,
    input  logic                     dirty,
    input  logic                     valid
);

    import cache_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        FILL,
        RESPOND
    } state_t;

    state_t state;
    state_t state_nxt;
    logic   op_wr;
    logic   [`CACHE_ADDR_W-1:0] addr_q;
    word_t  wdata_q;
    tag_t   mem_tag;

    // Address fields of the registered request
    assign tag_in   = addr_q[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
    assign index    = addr_q[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
    assign word_sel = addr_q[`CACHE_OFFSET_W-1:2];
    assign data_in  = wdata_q;
    assign line_in  = mem_rline;

    // Array controls
    assign en           = (state == LOOKUP) | (state == FILL);
    assign comp         = (state == LOOKUP);
    assign wr           = (state == LOOKUP) & op_wr;
    assign replace_line = (state == FILL) & mem_ack;

    // Memory port, victim tag during writeback and request tag during fill
    assign mem_req   = (state == WRITEBACK) | (state == FILL);
    assign mem_wr    = (state == WRITEBACK);
    assign mem_tag   = (state == WRITEBACK) ? tag_out : tag_in;
    assign mem_addr  = {mem_tag, index, {`CACHE_OFFSET_W{1'b0}}};
    assign mem_wline = line_out;

    assign req_ready = (state == IDLE);
    assign rsp_valid = (state == RESPOND);

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (req_valid) begin
                    state_nxt = LOOKUP;
                end
            end
            LOOKUP: begin
                if (hit) begin
                    state_nxt = RESPOND;
                end else if (dirty & valid) begin
                    state_nxt = WRITEBACK;
                end else begin
                    state_nxt = FILL;
                end
            end
            WRITEBACK: begin
                if (mem_ack) begin
                    state_nxt = FILL;
                end
            end
            // Lookup again after the fill, which then hits
            FILL: begin
                if (mem_ack) begin
                    state_nxt = LOOKUP;
                end
            end
            RESPOND: state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            op_wr <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == IDLE && req_valid) begin
                op_wr <= req_wr;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && req_valid) begin
            addr_q  <= req_addr;
            wdata_q <= req_wdata;
        end
        if (state == LOOKUP && hit) begin
            rsp_rdata <= data_out;
        end
    end

endmodule

//--- design/cache_macros.svh
// Cache geometry macros: address, tag, index and offset widths, words per line, line count
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// Byte address width seen by the CPU
`define CACHE_ADDR_W 32

// Address split: tag | index | byte offset
`define CACHE_TAG_W 18
`define CACHE_INDEX_W 8
`define CACHE_OFFSET_W 6

// 16 words of 32 bits make one 64-byte line
`define CACHE_WORDS 16

// Direct mapped, one line per index
`define CACHE_LINES 256

`endif

//--- design/cache_pkg.sv
// Package cache_pkg: word, tag, index, word select, line and AXI response types
`include "cache_macros.svh"

package cache_pkg;

    typedef logic [31:0] word_t;

    typedef logic [`CACHE_TAG_W-1:0] tag_t;

    typedef logic [`CACHE_INDEX_W-1:0] index_t;

    // Word number within a line, taken from offset bits 5:2
    typedef logic [`CACHE_OFFSET_W-3:0] word_sel_t;

    // Word 0 sits in bits 31:0
    typedef logic [`CACHE_WORDS*32-1:0] line_t;

    // Only OKAY and SLVERR are ever returned
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } resp_t;

endpackage

//--- design/cache_top.sv
// Module cache_top: AXI4-Lite port, miss controller and cache array
`timescale 1ns/1ps
`include "cache_macros.svh"

module cache_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     awvalid,
    output logic                     awready,
    input  logic [`CACHE_ADDR_W-1:0] awaddr,
    input  logic                     wvalid,
    output logic                     wready,
    input  cache_pkg::word_t         wdata,
    input  logic [3:0]               wstrb,
    output logic                     bvalid,
    input  logic                     bready,
    output cache_pkg::resp_t         bresp,
    input  logic                     arvalid,
    output logic                     arready,
    input  logic [`CACHE_ADDR_W-1:0] araddr,
    output logic                     rvalid,
    input  logic                     rready,
    output cache_pkg::word_t         rdata,
    output cache_pkg::resp_t         rresp,
    output logic                     mem_req,
    output logic                     mem_wr,
    output logic [`CACHE_ADDR_W-1:0] mem_addr,
    output cache_pkg::line_t         mem_wline,
    input  logic                     mem_ack,
    input  cache_pkg::line_t         mem_rline
);

    import cache_pkg::*;

    // Port to controller
    logic req_valid;
    logic req_wr;
    logic req_ready;
    logic rsp_valid;
    logic [`CACHE_ADDR_W-1:0] req_addr;
    word_t req_wdata;
    word_t rsp_rdata;

    // Controller to array
    logic en;
    logic comp;
    logic wr;
    logic replace_line;
    logic hit;
    logic dirty;
    logic valid;
    tag_t tag_in;
    tag_t tag_out;
    index_t index;
    word_sel_t word_sel;
    word_t data_in;
    word_t data_out;
    line_t line_in;
    line_t line_out;

    axil_cache_port u_port (
        .clk       (clk),
        .rst_n     (rst_n),
        .awvalid   (awvalid),
        .awready   (awready),
        .awaddr    (awaddr),
        .wvalid    (wvalid),
        .wready    (wready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .bvalid    (bvalid),
        .bready    (bready),
        .bresp     (bresp),
        .arvalid   (arvalid),
        .arready   (arready),
        .araddr    (araddr),
        .rvalid    (rvalid),
        .rready    (rready),
        .rdata     (rdata),
        .rresp     (rresp),
        .req_valid (req_valid),
        .req_wr    (req_wr),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .rsp_rdata (rsp_rdata)
    );

    cache_ctrl u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_valid    (req_valid),
        .req_wr       (req_wr),
        .req_addr     (req_addr),
        .req_wdata    (req_wdata),
        .req_ready    (req_ready),
        .rsp_valid    (rsp_valid),
        .rsp_rdata    (rsp_rdata),
        .mem_req      (mem_req),
        .mem_wr       (mem_wr),
        .mem_addr     (mem_addr),
        .mem_wline    (mem_wline),
        .mem_ack      (mem_ack),
        .mem_rline    (mem_rline),
        .en           (en),
        .comp         (comp),
        .wr           (wr),
        .replace_line (replace_line),
        .tag_in       (tag_in),
        .index        (index),
        .word_sel     (word_sel),
        .data_in      (data_in),
        .line_in      (line_in),
        .data_out     (data_out),
        .line_out     (line_out),
        .tag_out      (tag_out),
        .hit          (hit),
        .dirty        (dirty),
        .valid        (valid)
    );

    cpu_cache u_cache (
        .clk          (clk),
        .rst_n        (rst_n),
        .en           (en),
        .comp         (comp),
        .wr           (wr),
        .replace_line (replace_line),
        .tag_in       (tag_in),
        .index        (index),
        .word_sel     (word_sel),
        .data_in      (data_in),
        .line_in      (line_in),
        .data_out     (data_out),
        .line_out     (line_out),
        .tag_out      (tag_out),
        .hit          (hit),
        .dirty        (dirty),
        .valid        (valid)
    );

endmodule

//--- design/cpu_cache.sv
// Module cpu_cache: data, tag, dirty and valid arrays with hit detection and word mux
`timescale 1ns/1ps
`include "cache_macros.svh"

module cpu_cache (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 en,
    input  logic                 comp,
    input  logic                 wr,
    input  logic                 replace_line,
    input  cache_pkg::tag_t      tag_in,
    input  cache_pkg::index_t    index,
    input  cache_pkg::word_sel_t word_sel,
    input  cache_pkg::word_t     data_in,
    input  cache_pkg::line_t     line_in,
    output cache_pkg::word_t     data_out,
    output cache_pkg::line_t     line_out,
    output cache_pkg::tag_t      tag_out,
    output logic                 hit,
    output logic                 dirty,
    output logic                 valid
);

    import cache_pkg::*;

    word_t word_q [`CACHE_WORDS];
    word_t word_d [`CACHE_WORDS];
    logic  [`CACHE_WORDS-1:0] word_we;
    logic  match;
    logic  word_wr;
    logic  dirty_we;
    logic  fill_we;

    // Stored tag agrees and the line holds data
    assign match = valid & (tag_out == tag_in);
    assign hit   = en & match;

    // Compare-write only lands on a matching line
    assign word_wr  = en & wr & comp & match;
    assign fill_we  = en & replace_line;
    assign dirty_we = word_wr | fill_we;

    for (genvar w = 0; w < `CACHE_WORDS; w++) begin : g_word
        assign word_we[w] = fill_we | (word_wr & (word_sel == word_sel_t'(w)));
        assign word_d[w]  = replace_line ? line_in[w*$bits(word_t) +: $bits(word_t)] : data_in;
        assign line_out[w*$bits(word_t) +: $bits(word_t)] = word_q[w];

        ram_block #(.payload_t(word_t)) u_word (
            .clk   (clk),
            .rst_n (rst_n),
            .index (index),
            .d     (word_d[w]),
            .wr_en (word_we[w]),
            .q     (word_q[w])
        );
    end

    ram_block #(.payload_t(tag_t)) u_tag (
        .clk   (clk),
        .rst_n (rst_n),
        .index (index),
        .d     (tag_in),
        .wr_en (fill_we),
        .q     (tag_out)
    );

    // Fill clears dirty, a word write sets it
    ram_block #(.payload_t(logic)) u_dirty (
        .clk   (clk),
        .rst_n (rst_n),
        .index (index),
        .d     (~replace_line),
        .wr_en (dirty_we),
        .q     (dirty)
    );

    ram_block #(.payload_t(logic)) u_valid (
        .clk   (clk),
        .rst_n (rst_n),
        .index (index),
        .d     (1'b1),
        .wr_en (fill_we),
        .q     (valid)
    );

    assign data_out = word_q[word_sel];

endmodule

//--- design/ram_block.sv
// Module ram_block: per-index storage with a type-parameterized payload
`timescale 1ns/1ps
`include "cache_macros.svh"

module ram_block #(
    parameter type payload_t = logic
) (
    input  logic              clk,
    input  logic              rst_n,
    input  cache_pkg::index_t index,
    input  payload_t          d,
    input  logic              wr_en,
    output payload_t          q
);

    payload_t mem [`CACHE_LINES];

    // Combinational read of the indexed entry
    assign q = mem[index];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `CACHE_LINES; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en) begin
            mem[index] <= d;
        end
    end

endmodule

//--- sim.f
+incdir+design
design/cache_pkg.sv
design/ram_block.sv
design/cpu_cache.sv
design/cache_ctrl.sv
design/axil_cache_port.sv
design/cache_top.sv
verif/cache_checker.sv
verif/cache_tb.sv

//--- verif/cache_checker.sv
// Module cache_checker: AXI response and memory request stability assertions, bound to cache_top
`timescale 1ns/1ps
`include "cache_macros.svh"

module cache_checker (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     arvalid,
    input logic                     arready,
    input logic                     awvalid,
    input logic                     awready,
    input logic                     wvalid,
    input logic                     wready,
    input logic                     bvalid,
    input logic                     bready,
    input cache_pkg::resp_t         bresp,
    input logic                     rvalid,
    input logic                     rready,
    input cache_pkg::word_t         rdata,
    input cache_pkg::resp_t         rresp,
    input logic                     mem_req,
    input logic                     mem_wr,
    input logic [`CACHE_ADDR_W-1:0] mem_addr,
    input logic                     mem_ack
);

    // Any accepted AXI request sets it and the B or R handshake clears it
    logic busy;
    int   assert_fails = 0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else if ((bvalid & bready) | (rvalid & rready)) begin
            busy <= 1'b0;
        end else if ((arvalid & arready) | (awvalid & awready) | (wvalid & wready)) begin
            busy <= 1'b1;
        end
    end

    r_stable: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
        else begin
            assert_fails++;
            $error("rvalid dropped or read data changed while rready was low");
        end

    b_stable: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else begin
            assert_fails++;
            $error("bvalid dropped or bresp changed while bready was low");
        end

    mem_stable: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req && !mem_ack |=> mem_req && $stable(mem_addr) && $stable(mem_wr))
        else begin
            assert_fails++;
            $error("mem_req dropped or its address changed before mem_ack");
        end

    rsp_has_req: assert property (@(posedge clk) disable iff (!rst_n)
        ($rose(bvalid) || $rose(rvalid)) |-> busy)
        else begin
            assert_fails++;
            $error("response raised with no request in progress");
        end

endmodule

bind cache_top cache_checker u_checker (.*);

//--- verif/cache_tb.sv
// Module cache_tb: clock, reset, memory model, shadow cache, stimulus table loop, checks, timeout
`timescale 1ns/1ps
`include "cache_macros.svh"

module cache_tb;

    import cache_pkg::*;

    typedef struct packed {
        bit                       is_wr;
        logic [`CACHE_ADDR_W-1:0] addr;
        word_t                    wdata;
        logic [3:0]               strb;
        int                       stall;
        word_t                    exp_data;
        resp_t                    exp_resp;
        int                       exp_wb;
        int                       exp_fill;
        logic [`CACHE_ADDR_W-1:0] exp_wb_addr;
        line_t                    exp_wb_line;
    } entry_t;

    logic clk;
    logic rst_n;
    logic awvalid;
    logic awready;
    logic [`CACHE_ADDR_W-1:0] awaddr;
    logic wvalid;
    logic wready;
    word_t wdata;
    logic [3:0] wstrb;
    logic bvalid;
    logic bready;
    resp_t bresp;
    logic arvalid;
    logic arready;
    logic [`CACHE_ADDR_W-1:0] araddr;
    logic rvalid;
    logic rready;
    word_t rdata;
    resp_t rresp;
    logic mem_req;
    logic mem_wr;
    logic [`CACHE_ADDR_W-1:0] mem_addr;
    line_t mem_wline;
    logic mem_ack;
    line_t mem_rline;

    // Memory behind the cache and its traffic log
    line_t mem_lines [bit [`CACHE_ADDR_W-1:0]];
    logic [`CACHE_ADDR_W-1:0] wb_addr_q [$];
    line_t wb_line_q [$];
    int ack_delay_q [$];
    int wb_count = 0;
    int fill_count = 0;

    // Shadow of the cache state and of memory as the cache should see it
    tag_t  sh_tag   [`CACHE_LINES];
    bit    sh_valid [`CACHE_LINES];
    bit    sh_dirty [`CACHE_LINES];
    line_t sh_line  [`CACHE_LINES];
    line_t sh_mem   [bit [`CACHE_ADDR_W-1:0]];

    entry_t table_q [$];
    int errors = 0;
    int pass_count = 0;
    int fail_count = 0;
    int cycles = 0;
    int limit = 0;

    cache_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Every word of an untouched line is a hash of its own byte address
    function automatic line_t pattern_line(input logic [`CACHE_ADDR_W-1:0] base);
        line_t l;
        logic [`CACHE_ADDR_W-1:0] a;
        for (int w = 0; w < `CACHE_WORDS; w++) begin
            a = base + 32'(w * 4);
            l[w*32 +: 32] = (a * 32'h9E37_79B1) ^ 32'h5A5A_C3C3;
        end
        return l;
    endfunction

    function automatic line_t read_mem(input logic [`CACHE_ADDR_W-1:0] a);
        return mem_lines.exists(a) ? mem_lines[a] : pattern_line(a);
    endfunction

    function automatic line_t shadow_mem(input logic [`CACHE_ADDR_W-1:0] a);
        return sh_mem.exists(a) ? sh_mem[a] : pattern_line(a);
    endfunction

    task automatic check(input string what, input logic [511:0] got, input logic [511:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s got %0h expected %0h", $time, what, got, exp);
            errors++;
        end
    endtask

    // Predict one request with the shadow cache, then queue it
    task automatic add_op(input bit is_wr, input logic [`CACHE_ADDR_W-1:0] addr,
                          input word_t wd, input logic [3:0] strb, input int stall);
        entry_t e;
        tag_t t;
        index_t ix;
        int w;
        logic [`CACHE_ADDR_W-1:0] base;
        e = '0;
        e.is_wr = is_wr;
        e.addr = addr;
        e.wdata = wd;
        e.strb = strb;
        e.stall = stall;
        t = addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
        ix = addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
        w = addr[`CACHE_OFFSET_W-1:2];
        base = {addr[`CACHE_ADDR_W-1:`CACHE_OFFSET_W], {`CACHE_OFFSET_W{1'b0}}};
        if (addr[1:0] != 2'b00 || (is_wr && strb != 4'hf)) begin
            e.exp_resp = RESP_SLVERR;
        end else begin
            e.exp_resp = RESP_OKAY;
            if (!(sh_valid[ix] && sh_tag[ix] == t)) begin
                // Dirty victim goes back to memory at its old tag
                if (sh_valid[ix] && sh_dirty[ix]) begin
                    e.exp_wb = 1;
                    e.exp_wb_addr = {sh_tag[ix], ix, {`CACHE_OFFSET_W{1'b0}}};
                    e.exp_wb_line = sh_line[ix];
                    sh_mem[e.exp_wb_addr] = sh_line[ix];
                end
                e.exp_fill = 1;
                sh_line[ix] = shadow_mem(base);
                sh_tag[ix] = t;
                sh_valid[ix] = 1'b1;
                sh_dirty[ix] = 1'b0;
            end
            if (is_wr) begin
                sh_line[ix][w*32 +: 32] = wd;
                sh_dirty[ix] = 1'b1;
            end else begin
                e.exp_data = sh_line[ix][w*32 +: 32];
            end
        end
        table_q.push_back(e);
    endtask

    task automatic build_table();
        add_op(0, 32'h0000_1240, '0, 4'hf, 0);
        add_op(0, 32'h0003_8084, '0, 4'hf, 0);
        add_op(1, 32'h0000_1248, 32'hDEAD_BEEF, 4'hf, 0);
        add_op(0, 32'h0000_1248, '0, 4'hf, 0);
        add_op(0, 32'h0000_127C, '0, 4'hf, 0);
        add_op(1, 32'h0000_1250, 32'h1234_5678, 4'hf, 0);
        // Same index 0x49 with a new tag evicts a dirty victim
        add_op(0, 32'h0005_1240, '0, 4'hf, 0);
        add_op(0, 32'h0000_1248, '0, 4'hf, 0);
        // Clean eviction at index 0x02 and refill
        add_op(0, 32'h0007_8080, '0, 4'hf, 0);
        add_op(0, 32'h0003_8084, '0, 4'hf, 0);
        add_op(0, 32'h0000_1242, '0, 4'hf, 0);
        add_op(1, 32'h0000_1248, 32'hFFFF_FFFF, 4'h3, 0);
        add_op(1, 32'h0000_1249, 32'hFFFF_FFFF, 4'hf, 0);
        add_op(0, 32'h0000_1248, '0, 4'hf, 0);
        add_op(1, 32'h0000_2000, 32'hCAFE_F00D, 4'hf, $urandom_range(12, 1));
        add_op(0, 32'h0000_2000, '0, 4'hf, $urandom_range(12, 1));
        add_op(0, 32'h0000_1250, '0, 4'hf, $urandom_range(12, 1));
        add_op(1, 32'h0004_2000, 32'h0BAD_CAFE, 4'hf, $urandom_range(12, 1));
        add_op(0, 32'h0000_2000, '0, 4'hf, $urandom_range(12, 1));
    endtask

    task automatic apply_entry(input int n);
        entry_t e;
        int err0;
        int wb0;
        int fill0;
        bit ar_done;
        bit aw_done;
        bit w_done;
        bit take_ar;
        bit take_aw;
        bit take_w;
        word_t got_data;
        resp_t got_resp;
        e = table_q[n];
        err0 = errors;
        wb0 = wb_count;
        fill0 = fill_count;
        @(negedge clk);
        if (e.is_wr) begin
            awvalid = 1'b1;
            awaddr = e.addr;
            wvalid = 1'b1;
            wdata = e.wdata;
            wstrb = e.strb;
        end else begin
            arvalid = 1'b1;
            araddr = e.addr;
        end
        ar_done = e.is_wr;
        aw_done = !e.is_wr;
        w_done = !e.is_wr;
        // Readies settle well before the rising edge
        while (!(ar_done && aw_done && w_done)) begin
            #1;
            take_ar = arvalid & arready;
            take_aw = awvalid & awready;
            take_w = wvalid & wready;
            @(negedge clk);
            ar_done |= take_ar;
            aw_done |= take_aw;
            w_done |= take_w;
            if (take_ar) arvalid = 1'b0;
            if (take_aw) awvalid = 1'b0;
            if (take_w) wvalid = 1'b0;
        end
        while (!(bvalid | rvalid)) @(negedge clk);
        check("bvalid", bvalid, e.is_wr);
        check("rvalid", rvalid, !e.is_wr);
        // No new request may be taken while the response is held back
        repeat (e.stall) begin
            check("arready while response held", arready, 1'b0);
            check("awready while response held", awready, 1'b0);
            check("wready while response held", wready, 1'b0);
            @(negedge clk);
        end
        got_data = rdata;
        got_resp = e.is_wr ? bresp : rresp;
        bready = e.is_wr;
        rready = !e.is_wr;
        @(negedge clk);
        bready = 1'b0;
        rready = 1'b0;
        check("valid after response handshake", bvalid | rvalid, 1'b0);
        check("response code", got_resp, e.exp_resp);
        if (!e.is_wr && e.exp_resp == RESP_OKAY) begin
            check("read data", got_data, e.exp_data);
        end
        check("writeback count", wb_count - wb0, e.exp_wb);
        check("fill count", fill_count - fill0, e.exp_fill);
        if (e.exp_wb > 0 && wb_count > wb0) begin
            check("writeback address", wb_addr_q[$], e.exp_wb_addr);
            check("writeback line", wb_line_q[$], e.exp_wb_line);
        end
        if (errors == err0) pass_count++;
        else fail_count++;
        $display("Test %2d: %s %h stall %0d %s", n, e.is_wr ? "write" : "read ", e.addr,
                 e.stall, (errors == err0) ? "PASS" : "FAIL");
    endtask

    // Line-wide memory that acks 1 to 5 cycles after the request
    initial begin : mem_model
        int delay;
        forever begin
            @(negedge clk);
            mem_ack = 1'b0;
            if (mem_req) begin
                delay = (ack_delay_q.size() > 0) ? ack_delay_q.pop_front() : 1;
                repeat (delay - 1) @(negedge clk);
                if (mem_wr) begin
                    mem_lines[mem_addr] = mem_wline;
                    wb_addr_q.push_back(mem_addr);
                    wb_line_q.push_back(mem_wline);
                    wb_count++;
                end else begin
                    mem_rline = read_mem(mem_addr);
                    fill_count++;
                end
                mem_ack = 1'b1;
            end
        end
    end

    initial begin : watchdog
        wait (limit > 0);
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: timed out waiting for a response after %0d cycles", cycles);
        $display("Verification failed");
        $finish;
    end

    initial begin : main
        int err0;
        int sva_fails;
        void'($urandom(38));
        rst_n = 1'b0;
        awvalid = 1'b0;
        awaddr = '0;
        wvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        bready = 1'b0;
        arvalid = 1'b0;
        araddr = '0;
        rready = 1'b0;
        mem_ack = 1'b0;
        mem_rline = '0;
        build_table();
        // At most one writeback and one fill per entry
        repeat (table_q.size() * 2) begin
            ack_delay_q.push_back($urandom_range(5, 1));
        end
        limit = table_q.size() * 60 + 16;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        err0 = errors;
        check("bvalid after reset", bvalid, 1'b0);
        check("rvalid after reset", rvalid, 1'b0);
        check("mem_req after reset", mem_req, 1'b0);
        check("arready after reset", arready, 1'b1);
        check("awready after reset", awready, 1'b1);
        check("wready after reset", wready, 1'b1);
        if (errors == err0) pass_count++;
        else fail_count++;
        $display("Test reset state: %s", (errors == err0) ? "PASS" : "FAIL");
        for (int i = 0; i < table_q.size(); i++) begin
            apply_entry(i);
        end
        sva_fails = dut0.u_checker.assert_fails;
        if (sva_fails == 0) pass_count++;
        else fail_count++;
        $display("Test bound assertions: %0d failures %s", sva_fails,
                 (sva_fails == 0) ? "PASS" : "FAIL");
        $display("Summary: %0d tests passed, %0d tests failed", pass_count, fail_count);
        if (fail_count == 0 && errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
